// ==== verilog/oramPkg.sv ====
// Tree geometry, field widths and DRAM slot layout shared by the backend.
// One DRAM word holds one bucket slot. Layout assumes ORAMZ * 15 <= 64.
package oramPkg;

	// Tree depth, leaves 0..2**ORAML-1
	localparam int ORAML = 3;

	typedef logic [ORAML-1:0] leafT;
	typedef logic [7:0] pAddrT;
	typedef logic [31:0] blockDataT;
	typedef logic [1:0] levelT;
	typedef logic [5:0] dramAddrT;
	typedef logic [43:0] dramWordT;

	//--------------------------------------------------------------------------
	// Slot word fields, valid bit on top
	//--------------------------------------------------------------------------
	localparam int DataLsb = 0;
	localparam int LeafLsb = DataLsb + $bits(blockDataT);
	localparam int AddrLsb = LeafLsb + $bits(leafT);
	localparam int ValidPos = AddrLsb + $bits(pAddrT);

	typedef enum logic {
		CmdRead,
		CmdWrite
	} cmdT;

	// DRAM word of a slot on a leaf's path; heap index is 2**level + (leaf >> (L - level))
	function automatic dramAddrT slotAddr(input leafT leaf, input levelT level,
			input int unsigned slot, input int unsigned z);
		int unsigned heap;
		heap = (32'd1 << level) + (32'(leaf) >> (ORAML - int'(level)));
		return dramAddrT'((heap - 1) * z + slot);
	endfunction

endpackage

// ==== verilog/pathReader.sv ====
// Accepts one frontend command at a time and reads its path root first.
// DRAM returns arrive in request order; only valid slots reach the stash.
`timescale 1ns/10ps

module pathReader #(
	parameter int ORAMZ = 2
) (
	input logic Clock,
	input logic rstN,
	input oramPkg::cmdT Command,
	input oramPkg::pAddrT PAddr,
	input oramPkg::leafT CurrentLeaf,
	input oramPkg::leafT RemappedLeaf,
	input logic CommandValid,
	output logic CommandReady,
	output oramPkg::dramAddrT DRAMReadAddress,
	output logic DRAMReadValid,
	input logic DRAMReadReady,
	input oramPkg::dramWordT DRAMReadData,
	input logic DRAMReadDataValid,
	output logic insertValid,
	output oramPkg::dramWordT insertWord,
	output logic accessStart,
	output oramPkg::cmdT accCmd,
	output oramPkg::pAddrT accAddr,
	output oramPkg::leafT accLeaf,
	output oramPkg::leafT pathLeaf,
	input logic accessDone
);

	localparam int NWords = (oramPkg::ORAML + 1) * ORAMZ;
	localparam int SlotW = (ORAMZ > 1) ? $clog2(ORAMZ) : 1;
	localparam int CntW = $clog2(NWords + 1);

	typedef enum logic [1:0] {
		RdIdle,
		RdFetch,
		RdWait
	} readStateT;

	readStateT state;
	oramPkg::levelT reqLevel, nxtLevel;
	logic [SlotW-1:0] reqSlot, nxtSlot;
	logic [CntW-1:0] retCount;
	logic lastReq;

	assign CommandReady = (state == RdIdle);

	// Invalid slots are dummies and never enter the stash
	assign insertValid = (state == RdFetch) && DRAMReadDataValid &&
		DRAMReadData[oramPkg::ValidPos];
	assign insertWord = DRAMReadData;

	//--------------------------------------------------------------------------
	// Request walk, slot first then one level deeper
	//--------------------------------------------------------------------------
	always_comb begin
		nxtSlot = reqSlot + 1'b1;
		nxtLevel = reqLevel;
		if (reqSlot == SlotW'(ORAMZ - 1)) begin
			nxtSlot = '0;
			nxtLevel = reqLevel + 1'b1;
		end
	end

	assign lastReq = (reqLevel == oramPkg::levelT'(oramPkg::ORAML)) &&
		(reqSlot == SlotW'(ORAMZ - 1));

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			state <= RdIdle;
			DRAMReadValid <= 1'b0;
			accessStart <= 1'b0;
			reqLevel <= '0;
			reqSlot <= '0;
			retCount <= '0;
		end else begin
			accessStart <= 1'b0;
			case (state)
				RdIdle: if (CommandValid) begin
					DRAMReadValid <= 1'b1;
					reqLevel <= '0;
					reqSlot <= '0;
					retCount <= '0;
					state <= RdFetch;
				end
				RdFetch: begin
					if (DRAMReadValid && DRAMReadReady) begin
						if (lastReq) begin
							DRAMReadValid <= 1'b0;
						end else begin
							reqLevel <= nxtLevel;
							reqSlot <= nxtSlot;
						end
					end
					if (DRAMReadDataValid) begin
						retCount <= retCount + 1'b1;
						if (retCount == CntW'(NWords - 1)) begin
							accessStart <= 1'b1;
							state <= RdWait;
						end
					end
				end
				// Stash service and eviction run here
				RdWait: if (accessDone) state <= RdIdle;
				default: state <= RdIdle;
			endcase
		end
	end

	// Command fields and the next read address
	always_ff @(posedge Clock) begin
		if (state == RdIdle && CommandValid) begin
			accCmd <= Command;
			accAddr <= PAddr;
			accLeaf <= RemappedLeaf;
			pathLeaf <= CurrentLeaf;
			DRAMReadAddress <= oramPkg::slotAddr(CurrentLeaf, '0, 0, ORAMZ);
		end else if (state == RdFetch && DRAMReadValid && DRAMReadReady && !lastReq) begin
			DRAMReadAddress <= oramPkg::slotAddr(pathLeaf, nxtLevel, 32'(nxtSlot), ORAMZ);
		end
	end

endmodule

// ==== verilog/stash.sv ====
// Block store between path read and eviction. A full stash drops inserts,
// so StashCap must cover one path plus the blocks left over from earlier paths.
`timescale 1ns/10ps

module stash #(
	parameter int StashCap = 16
) (
	input logic Clock,
	input logic rstN,
	input logic insertValid,
	input oramPkg::dramWordT insertWord,
	input logic accessStart,
	input oramPkg::cmdT accCmd,
	input oramPkg::pAddrT accAddr,
	input oramPkg::leafT accLeaf,
	input oramPkg::leafT pathLeaf,
	output oramPkg::blockDataT LoadData,
	output logic LoadValid,
	input logic LoadReady,
	input oramPkg::blockDataT StoreData,
	input logic StoreValid,
	output logic StoreReady,
	output logic evictStart,
	input oramPkg::levelT evictLevel,
	input logic evictTake,
	output logic candValid,
	output oramPkg::dramWordT candWord
);

	localparam int IdxW = (StashCap > 1) ? $clog2(StashCap) : 1;

	typedef logic [IdxW-1:0] idxT;

	typedef enum logic [1:0] {
		StIdle,
		StLoad,
		StStore
	} stashStateT;

	stashStateT state;
	logic [StashCap-1:0] entryValid;
	oramPkg::pAddrT entryAddr [StashCap];
	oramPkg::leafT entryLeaf [StashCap];
	oramPkg::blockDataT entryData [StashCap];

	idxT freeIdx, hitIdx, candIdx, svcSel, svcIdx;
	logic freeFound, hitFound;
	oramPkg::levelT dropBits;

	// Leaf bits below the eviction level do not matter
	assign dropBits = oramPkg::levelT'(oramPkg::ORAML) - evictLevel;

	//--------------------------------------------------------------------------
	// Priority searches, lowest index wins
	//--------------------------------------------------------------------------
	always_comb begin
		freeFound = 1'b0;
		freeIdx = '0;
		hitFound = 1'b0;
		hitIdx = '0;
		candValid = 1'b0;
		candIdx = '0;
		for (int i = StashCap - 1; i >= 0; i--) begin
			if (!entryValid[i]) begin
				freeFound = 1'b1;
				freeIdx = idxT'(i);
			end
			if (entryValid[i] && entryAddr[i] == accAddr) begin
				hitFound = 1'b1;
				hitIdx = idxT'(i);
			end
			if (entryValid[i] && ((entryLeaf[i] ^ pathLeaf) >> dropBits) == '0) begin
				candValid = 1'b1;
				candIdx = idxT'(i);
			end
		end
	end

	// Missing block gets a fresh entry
	assign svcSel = hitFound ? hitIdx : freeIdx;

	always_comb begin
		candWord = '0;
		if (candValid) begin
			candWord[oramPkg::ValidPos] = 1'b1;
			candWord[oramPkg::AddrLsb +: $bits(oramPkg::pAddrT)] = entryAddr[candIdx];
			candWord[oramPkg::LeafLsb +: $bits(oramPkg::leafT)] = entryLeaf[candIdx];
			candWord[oramPkg::DataLsb +: $bits(oramPkg::blockDataT)] = entryData[candIdx];
		end
	end

	//--------------------------------------------------------------------------
	// Occupancy and frontend service
	//--------------------------------------------------------------------------
	always_ff @(posedge Clock) begin
		if (!rstN) begin
			state <= StIdle;
			entryValid <= '0;
			LoadValid <= 1'b0;
			StoreReady <= 1'b0;
			evictStart <= 1'b0;
		end else begin
			evictStart <= 1'b0;
			if (insertValid && freeFound) entryValid[freeIdx] <= 1'b1;
			if (evictTake) entryValid[candIdx] <= 1'b0;
			case (state)
				StIdle: if (accessStart) begin
					entryValid[svcSel] <= 1'b1;
					if (accCmd == oramPkg::CmdRead) begin
						LoadValid <= 1'b1;
						state <= StLoad;
					end else begin
						StoreReady <= 1'b1;
						state <= StStore;
					end
				end
				StLoad: if (LoadReady) begin
					LoadValid <= 1'b0;
					evictStart <= 1'b1;
					state <= StIdle;
				end
				StStore: if (StoreValid) begin
					StoreReady <= 1'b0;
					evictStart <= 1'b1;
					state <= StIdle;
				end
				default: state <= StIdle;
			endcase
		end
	end

	// Entry contents, remap happens at lookup time
	always_ff @(posedge Clock) begin
		if (insertValid && freeFound) begin
			entryAddr[freeIdx] <= insertWord[oramPkg::AddrLsb +: $bits(oramPkg::pAddrT)];
			entryLeaf[freeIdx] <= insertWord[oramPkg::LeafLsb +: $bits(oramPkg::leafT)];
			entryData[freeIdx] <= insertWord[oramPkg::DataLsb +: $bits(oramPkg::blockDataT)];
		end
		if (state == StIdle && accessStart) begin
			svcIdx <= svcSel;
			entryAddr[svcSel] <= accAddr;
			entryLeaf[svcSel] <= accLeaf;
			if (!hitFound) entryData[svcSel] <= '0;
			LoadData <= hitFound ? entryData[hitIdx] : '0;
		end
		if (state == StStore && StoreValid) entryData[svcIdx] <= StoreData;
	end

endmodule

// ==== verilog/pathWriter.sv ====
// Writes the whole path back, leaf bucket first, two cycles per slot at best.
// A slot with no legal stash block is filled with an all-zero dummy word.
`timescale 1ns/10ps

module pathWriter #(
	parameter int ORAMZ = 2
) (
	input logic Clock,
	input logic rstN,
	input logic evictStart,
	input oramPkg::leafT pathLeaf,
	output oramPkg::levelT evictLevel,
	output logic evictTake,
	input logic candValid,
	input oramPkg::dramWordT candWord,
	output oramPkg::dramAddrT DRAMWriteAddress,
	output oramPkg::dramWordT DRAMWriteData,
	output logic DRAMWriteValid,
	input logic DRAMWriteReady,
	output logic accessDone
);

	localparam int SlotW = (ORAMZ > 1) ? $clog2(ORAMZ) : 1;

	typedef enum logic [1:0] {
		WrIdle,
		WrLoad,
		WrSend
	} writeStateT;

	writeStateT state;
	oramPkg::levelT level;
	logic [SlotW-1:0] slot;
	logic lastSlot;

	assign evictLevel = level;

	// Candidate is removed in the cycle it is captured
	assign evictTake = (state == WrLoad) && candValid;

	assign lastSlot = (level == '0) && (slot == SlotW'(ORAMZ - 1));

	//--------------------------------------------------------------------------
	// Eviction walk
	//--------------------------------------------------------------------------
	always_ff @(posedge Clock) begin
		if (!rstN) begin
			state <= WrIdle;
			level <= '0;
			slot <= '0;
			DRAMWriteValid <= 1'b0;
			accessDone <= 1'b0;
		end else begin
			accessDone <= 1'b0;
			case (state)
				WrIdle: if (evictStart) begin
					level <= oramPkg::levelT'(oramPkg::ORAML);
					slot <= '0;
					state <= WrLoad;
				end
				WrLoad: begin
					DRAMWriteValid <= 1'b1;
					state <= WrSend;
				end
				WrSend: if (DRAMWriteReady) begin
					DRAMWriteValid <= 1'b0;
					if (lastSlot) begin
						accessDone <= 1'b1;
						state <= WrIdle;
					end else begin
						state <= WrLoad;
						if (slot == SlotW'(ORAMZ - 1)) begin
							slot <= '0;
							level <= level - 1'b1;
						end else begin
							slot <= slot + 1'b1;
						end
					end
				end
				default: state <= WrIdle;
			endcase
		end
	end

	// Write payload, held until the transfer
	always_ff @(posedge Clock) begin
		if (state == WrLoad) begin
			DRAMWriteAddress <= oramPkg::slotAddr(pathLeaf, level, 32'(slot), ORAMZ);
			DRAMWriteData <= candValid ? candWord : '0;
		end
	end

endmodule

// ==== verilog/oramBackend.sv ====
// Path ORAM backend without encryption or integrity checks.
// The frontend keeps the position map and issues one access at a time.
`timescale 1ns/10ps

module oramBackend #(
	parameter int ORAMZ = 2,
	parameter int StashCap = 16
) (
	input logic Clock,
	input logic rstN,

	// Frontend
	input oramPkg::cmdT Command,
	input oramPkg::pAddrT PAddr,
	input oramPkg::leafT CurrentLeaf,
	input oramPkg::leafT RemappedLeaf,
	input logic CommandValid,
	output logic CommandReady,
	output oramPkg::blockDataT LoadData,
	output logic LoadValid,
	input logic LoadReady,
	input oramPkg::blockDataT StoreData,
	input logic StoreValid,
	output logic StoreReady,

	// DRAM
	output oramPkg::dramAddrT DRAMReadAddress,
	output logic DRAMReadValid,
	input logic DRAMReadReady,
	input oramPkg::dramWordT DRAMReadData,
	input logic DRAMReadDataValid,
	output oramPkg::dramAddrT DRAMWriteAddress,
	output oramPkg::dramWordT DRAMWriteData,
	output logic DRAMWriteValid,
	input logic DRAMWriteReady
);

	logic insertValid, accessStart, evictStart, evictTake, candValid, accessDone;
	oramPkg::dramWordT insertWord, candWord;
	oramPkg::cmdT accCmd;
	oramPkg::pAddrT accAddr;
	oramPkg::leafT accLeaf, pathLeaf;
	oramPkg::levelT evictLevel;

	//--------------------------------------------------------------------------
	// Read path, stash, write path
	//--------------------------------------------------------------------------
	pathReader #(.ORAMZ(ORAMZ)) reader0 (.*);

	stash #(.StashCap(StashCap)) stash0 (.*);

	pathWriter #(.ORAMZ(ORAMZ)) writer0 (.*);

endmodule

// ==== verif/oramBackend_props.sv ====
// Handshake, occupancy and eviction checks bound into the stash and the path writer.
// Payload width is set per bind. The writer instance ties all stash inputs low.
`timescale 1ns/10ps

module oramBackendProps #(
	parameter int StashCap = 16,
	parameter int PayloadW = 32
) (
	input logic Clock,
	input logic rstN,
	input logic chanValid,
	input logic chanReady,
	input logic [PayloadW-1:0] chanPayload,
	input logic [StashCap-1:0] entryValid,
	input logic entryNeeded,
	input logic evictTake,
	input logic candValid
);

	// Pending transfer keeps valid and payload
	validHeld: assert property (@(posedge Clock) disable iff (!rstN)
		chanValid && !chanReady |=> chanValid && $stable(chanPayload))
		else $error("Valid or payload changed before the transfer");

	// A block that needs an entry finds one free
	occupancyBound: assert property (@(posedge Clock) disable iff (!rstN)
		entryNeeded |-> $countones(entryValid) < StashCap)
		else $error("Stash full when a block needed an entry");

	// Only an offered entry can be taken
	takeWithOffer: assert property (@(posedge Clock) disable iff (!rstN)
		evictTake |-> candValid)
		else $error("Eviction take without a candidate");

	// Each take frees exactly one entry
	takeFrees: assert property (@(posedge Clock) disable iff (!rstN)
		evictTake |=> $countones(entryValid) + 1 == $past($countones(entryValid)))
		else $error("Eviction take did not free one stash entry");

endmodule

bind stash oramBackendProps #(
	.StashCap(StashCap),
	.PayloadW($bits(oramPkg::blockDataT))
) stashProps0 (
	.Clock(Clock),
	.rstN(rstN),
	.chanValid(LoadValid),
	.chanReady(LoadReady),
	.chanPayload(LoadData),
	.entryValid(entryValid),
	.entryNeeded(insertValid || (accessStart && !hitFound)),
	.evictTake(evictTake),
	.candValid(candValid)
);

bind pathWriter oramBackendProps #(
	.StashCap(1),
	.PayloadW($bits(oramPkg::dramAddrT) + $bits(oramPkg::dramWordT))
) writerProps0 (
	.Clock(Clock),
	.rstN(rstN),
	.chanValid(DRAMWriteValid),
	.chanReady(DRAMWriteReady),
	.chanPayload({DRAMWriteAddress, DRAMWriteData}),
	.entryValid(1'b0),
	.entryNeeded(1'b0),
	.evictTake(1'b0),
	.candValid(1'b0)
);

// ==== verif/oramBackendTb.sv ====
// Acts as ORAM frontend (position map, reference memory) and as the DRAM.
// Stops at the first mismatch; the random stream comes from a fixed seed.
`timescale 1ns/10ps

module oramBackendTb;

	localparam int unsigned ORAMZ = 2;
	localparam int StashCap = 16;
	localparam int NWords = (oramPkg::ORAML + 1) * ORAMZ;
	localparam int TreeSlots = ((1 << (oramPkg::ORAML + 1)) - 1) * ORAMZ;
	localparam int MemDepth = 1 << $bits(oramPkg::dramAddrT);
	localparam int Timeout = 1000;

	logic Clock, rstN;
	oramPkg::cmdT Command;
	oramPkg::pAddrT PAddr;
	oramPkg::leafT CurrentLeaf, RemappedLeaf;
	logic CommandValid, CommandReady;
	oramPkg::blockDataT LoadData, StoreData;
	logic LoadValid, LoadReady, StoreValid, StoreReady;
	oramPkg::dramAddrT DRAMReadAddress, DRAMWriteAddress;
	logic DRAMReadValid, DRAMReadReady, DRAMReadDataValid;
	oramPkg::dramWordT DRAMReadData, DRAMWriteData;
	logic DRAMWriteValid, DRAMWriteReady;

	// DRAM contents, frontend state
	oramPkg::dramWordT mem [MemDepth];
	oramPkg::leafT posMap [256];
	oramPkg::blockDataT refMem [256];
	logic written [256];
	oramPkg::leafT curLeaf;
	oramPkg::pAddrT curAddr;
	int rdCount, wrCount, loadCount;
	logic failPrinted, passPrinted;

	// Read returns in flight, in request order
	int unsigned tick, lastDue;
	int unsigned dueQ [$];
	oramPkg::dramWordT retQ [$];

	oramBackend #(.ORAMZ(ORAMZ), .StashCap(StashCap)) dut0 (.*);

	initial Clock = 1'b0;
	always #10 Clock = ~Clock;

	//--------------------------------------------------------------------------
	// Tree layout and reference model
	//--------------------------------------------------------------------------
	// Heap numbering, root is 1
	function automatic int unsigned bucketIndex(input oramPkg::leafT leaf,
			input int unsigned level);
		return (32'd1 << level) + (32'(leaf) >> (oramPkg::ORAML - level));
	endfunction

	function automatic int unsigned pathAddr(input oramPkg::leafT leaf,
			input int unsigned level, input int unsigned slot);
		return (bucketIndex(leaf, level) - 1) * ORAMZ + slot;
	endfunction

	function automatic logic onLeafPath(input oramPkg::leafT leaf, input int unsigned slotIdx);
		int unsigned d;
		for (d = 0; d <= oramPkg::ORAML; d++) begin
			if (bucketIndex(leaf, d) == slotIdx / ORAMZ + 1) return 1'b1;
		end
		return 1'b0;
	endfunction

	function automatic oramPkg::blockDataT expectedLoad(input oramPkg::pAddrT addr);
		return written[addr] ? refMem[addr] : '0;
	endfunction

	task automatic stopOnError(input string line);
		failPrinted = 1'b1;
		$display("%s", line);
		$display("*** TEST FAILED ***");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	//--------------------------------------------------------------------------
	// DRAM model and monitors
	//--------------------------------------------------------------------------
	always @(posedge Clock) begin : driveReady
		#1;
		DRAMReadReady = ($urandom_range(3, 0) != 0);
		DRAMWriteReady = ($urandom_range(3, 0) != 0);
		LoadReady = ($urandom_range(1, 0) != 0);
	end

	always @(posedge Clock) begin : readModel
		int unsigned due;
		tick = tick + 1;
		if (rstN && DRAMReadValid && DRAMReadReady) begin
			assert (rdCount < NWords && 32'(DRAMReadAddress) ==
					pathAddr(curLeaf, rdCount / ORAMZ, rdCount % ORAMZ))
				else stopOnError($sformatf("FAIL %0t: read %0d at address %0d off path of leaf %0d",
					$time, rdCount, DRAMReadAddress, curLeaf));
			rdCount++;
			// Latency 1 to 3 cycles, never overtaking
			due = tick + $urandom_range(2, 0);
			if (due <= lastDue) due = lastDue + 1;
			lastDue = due;
			dueQ.push_back(due);
			retQ.push_back(mem[DRAMReadAddress]);
		end
		#1;
		if (dueQ.size() > 0 && dueQ[0] <= tick) begin
			DRAMReadDataValid = 1'b1;
			DRAMReadData = retQ.pop_front();
			void'(dueQ.pop_front());
		end else begin
			DRAMReadDataValid = 1'b0;
			DRAMReadData = '0;
		end
	end

	always @(posedge Clock) begin : writeModel
		if (rstN && DRAMWriteValid && DRAMWriteReady) begin
			// Leaf bucket first, slot 0 first
			assert (wrCount < NWords && 32'(DRAMWriteAddress) == pathAddr(curLeaf,
					oramPkg::ORAML - wrCount / ORAMZ, wrCount % ORAMZ))
				else stopOnError($sformatf("FAIL %0t: write %0d at address %0d out of order",
					$time, wrCount, DRAMWriteAddress));
			wrCount++;
			mem[DRAMWriteAddress] = DRAMWriteData;
		end
	end

	always @(posedge Clock) begin : loadChecker
		if (rstN && LoadValid && LoadReady) begin
			assert (LoadData == expectedLoad(curAddr))
				else stopOnError($sformatf("FAIL %0t: load of %h returned %h, expected %h",
					$time, curAddr, LoadData, expectedLoad(curAddr)));
			loadCount++;
		end
	end

	// Placement rule and one copy per block
	task automatic checkDramLayout();
		int copies [256];
		oramPkg::dramWordT w;
		oramPkg::pAddrT a;
		oramPkg::leafT lf;
		int i;
		copies = '{default: 0};
		for (i = 0; i < TreeSlots; i++) begin
			w = mem[oramPkg::dramAddrT'(i)];
			if (w[oramPkg::ValidPos]) begin
				a = w[oramPkg::AddrLsb +: $bits(oramPkg::pAddrT)];
				lf = w[oramPkg::LeafLsb +: $bits(oramPkg::leafT)];
				copies[a]++;
				assert (onLeafPath(lf, i) && lf == posMap[a])
					else stopOnError($sformatf("FAIL %0t: block %h leaf %0d misplaced in slot %0d",
						$time, a, lf, i));
				assert (copies[a] == 1)
					else stopOnError($sformatf("FAIL %0t: block %h stored twice in DRAM", $time, a));
			end
		end
	endtask

	//--------------------------------------------------------------------------
	// Frontend access
	//--------------------------------------------------------------------------
	task automatic doAccess(input oramPkg::cmdT cmd, input oramPkg::pAddrT addr,
			input oramPkg::blockDataT data);
		oramPkg::leafT newLeaf;
		int waitCycles;
		int loadsBefore;
		newLeaf = oramPkg::leafT'($urandom_range((1 << oramPkg::ORAML) - 1, 0));
		curAddr = addr;
		curLeaf = posMap[addr];
		rdCount = 0;
		wrCount = 0;
		loadsBefore = loadCount;
		Command = cmd;
		PAddr = addr;
		CurrentLeaf = posMap[addr];
		RemappedLeaf = newLeaf;
		CommandValid = 1'b1;
		waitCycles = 0;
		do begin
			@(posedge Clock);
			waitCycles++;
			if (waitCycles > Timeout) stopOnError("Timeout: command was never accepted");
		end while (!CommandReady);
		#1;
		CommandValid = 1'b0;
		if (cmd == oramPkg::CmdWrite) begin
			StoreData = data;
			StoreValid = 1'b1;
			waitCycles = 0;
			do begin
				@(posedge Clock);
				waitCycles++;
				if (waitCycles > Timeout) stopOnError("Timeout: store data was never accepted");
			end while (!StoreReady);
			#1;
			StoreValid = 1'b0;
			refMem[addr] = data;
			written[addr] = 1'b1;
		end
		waitCycles = 0;
		do begin
			@(posedge Clock);
			waitCycles++;
			if (waitCycles > Timeout) stopOnError("Timeout: access never completed");
		end while (!CommandReady);
		posMap[addr] = newLeaf;
		assert (rdCount == NWords && wrCount == NWords)
			else stopOnError($sformatf("FAIL %0t: %0d reads and %0d writes for one access",
				$time, rdCount, wrCount));
		assert (loadCount - loadsBefore == ((cmd == oramPkg::CmdRead) ? 1 : 0))
			else stopOnError($sformatf("FAIL %0t: wrong number of loads for %h", $time, addr));
		checkDramLayout();
		#1;
	endtask

	initial begin : mainFlow
		int i;
		oramPkg::cmdT cmd;
		oramPkg::blockDataT data;
		void'($urandom(32'h0578_c51f));
		failPrinted = 1'b0;
		passPrinted = 1'b0;
		rstN = 1'b0;
		Command = oramPkg::CmdRead;
		PAddr = '0;
		CurrentLeaf = '0;
		RemappedLeaf = '0;
		CommandValid = 1'b0;
		LoadReady = 1'b0;
		StoreData = '0;
		StoreValid = 1'b0;
		DRAMReadReady = 1'b0;
		DRAMReadData = '0;
		DRAMReadDataValid = 1'b0;
		DRAMWriteReady = 1'b0;
		tick = 0;
		lastDue = 0;
		rdCount = 0;
		wrCount = 0;
		loadCount = 0;
		curLeaf = '0;
		curAddr = '0;
		mem = '{default: '0};
		refMem = '{default: '0};
		written = '{default: 1'b0};
		for (i = 0; i < 256; i++) begin
			posMap[oramPkg::pAddrT'(i)] =
				oramPkg::leafT'($urandom_range((1 << oramPkg::ORAML) - 1, 0));
		end

		repeat (2) @(posedge Clock);
		#1;
		rstN = 1'b1;
		assert (CommandReady && !LoadValid && !StoreReady && !DRAMReadValid && !DRAMWriteValid)
			else stopOnError($sformatf("FAIL %0t: outputs not idle after reset", $time));

		// Never written block reads as zero
		doAccess(oramPkg::CmdRead, 8'h40, '0);

		// Write then read back, each access remaps
		for (i = 0; i < 4; i++) begin
			data = $urandom();
			doAccess(oramPkg::CmdWrite, oramPkg::pAddrT'(8'h20 + i), data);
			doAccess(oramPkg::CmdRead, oramPkg::pAddrT'(8'h20 + i), '0);
			doAccess(oramPkg::CmdRead, oramPkg::pAddrT'(8'h20 + i), '0);
		end

		// Random mix over eight blocks
		for (i = 0; i < 200; i++) begin
			cmd = ($urandom_range(1, 0) == 1) ? oramPkg::CmdWrite : oramPkg::CmdRead;
			data = $urandom();
			doAccess(cmd, oramPkg::pAddrT'($urandom_range(7, 0)), data);
		end

		if (!failPrinted) begin
			passPrinted = 1'b1;
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	// Run ended before the sequence finished
	final begin
		if (!passPrinted && !failPrinted) $display("*** TEST FAILED ***");
	end

endmodule

// ==== oramBackend.f ====
verilog/oramPkg.sv
verilog/pathReader.sv
verilog/stash.sv
verilog/pathWriter.sv
verilog/oramBackend.sv
verif/oramBackend_props.sv
verif/oramBackendTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the ORAM backend testbench with Verilator
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module oramBackendTb \
	-f oramBackend.f \
	-o simOramBackend

status=0
./obj_dir/simOramBackend 2>&1 | tee sim.log || status=$?

if grep -qF "*** TEST FAILED ***" sim.log || [ "$status" -ne 0 ]; then
	echo "Simulation failed, see sim.log"
	exit 1
fi

echo "Simulation finished without errors"
exit 0
